// File: swu_params.svh
`ifndef SWU_PARAMS_SVH
`define SWU_PARAMS_SVH

// input feature map
`define SWU_IFM_W 3
`define SWU_IFM_H 3

// channels per pixel divided by simd
`define SWU_CH_GRP 2

// square kernel, stride 1
`define SWU_K 2
`define SWU_OFM_W (`SWU_IFM_W - `SWU_K + 1)
`define SWU_OFM_H (`SWU_IFM_H - `SWU_K + 1)

`define SWU_PIX_BITS 8

// needs (K-1)*IFM_W*CH_GRP + K*CH_GRP entries at least
`define SWU_BUF_SIZE 12

`define SWU_FRAME_WORDS (`SWU_IFM_W * `SWU_IFM_H * `SWU_CH_GRP)
`define SWU_WIN_WORDS (`SWU_OFM_W * `SWU_OFM_H * `SWU_K * `SWU_K * `SWU_CH_GRP)

`endif

// File: swu_pkg.sv
`default_nettype none

`include "swu_params.svh"

package swu_pkg;

   // one stream word, a channel group of one pixel
   typedef logic [`SWU_PIX_BITS-1:0] pix_t;

   // slot in the circular buffer
   typedef logic [$clog2(`SWU_BUF_SIZE)-1:0] buf_addr_t;

   // word index within a frame, wide enough for the full count
   typedef logic [$clog2(`SWU_FRAME_WORDS+1)-1:0] frame_idx_t;

   // read request from the window generator to the buffer
   typedef struct packed {
      buf_addr_t addr;
   } rd_req_t;

endpackage

`default_nettype wire

// File: swu_write_ctrl.sv
`default_nettype none

`include "swu_params.svh"

module swu_write_ctrl (
   input  wire                        clk,
   input  wire                        resetn,
   input  wire                        in_valid_i,
   input  wire                        frame_done_i,
   input  wire swu_pkg::frame_idx_t   release_idx_i,
   output logic                       in_ready_o,
   output logic                       wr_en_o,
   output swu_pkg::buf_addr_t         wr_addr_o,
   output swu_pkg::frame_idx_t        wr_count_o
);

   swu_pkg::frame_idx_t unreleased;
   logic frame_full;

   //////////////////////////////////////////////////////////////////////
   // flow control
   //////////////////////////////////////////////////////////////////////

   // words still needed by the current or a later window
   assign unreleased = wr_count_o - release_idx_i;
   assign frame_full = (wr_count_o == swu_pkg::frame_idx_t'(`SWU_FRAME_WORDS));

   assign in_ready_o = (unreleased < swu_pkg::frame_idx_t'(`SWU_BUF_SIZE)) && !frame_full;
   assign wr_en_o    = in_valid_i && in_ready_o;

   //////////////////////////////////////////////////////////////////////
   // write counter
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn || frame_done_i) begin
         wr_count_o <= '0;
         wr_addr_o  <= '0;
      end else if (wr_en_o) begin
         wr_count_o <= wr_count_o + 1'b1;
         // circular address, wraps at the buffer size
         if (wr_addr_o == swu_pkg::buf_addr_t'(`SWU_BUF_SIZE - 1)) begin
            wr_addr_o <= '0;
         end else begin
            wr_addr_o <= wr_addr_o + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: swu_window_gen.sv
`default_nettype none

`include "swu_params.svh"

module swu_window_gen (
   input  wire                        clk,
   input  wire                        resetn,
   input  wire swu_pkg::frame_idx_t   wr_count_i,
   input  wire                        room_i,
   output swu_pkg::rd_req_t           rd_req_o,
   output logic                       rd_fire_o,
   output swu_pkg::frame_idx_t        release_idx_o,
   output logic                       frame_done_o
);

   localparam int CH_BITS = (`SWU_CH_GRP > 1) ? $clog2(`SWU_CH_GRP) : 1;
   localparam int K_BITS  = (`SWU_K > 1) ? $clog2(`SWU_K) : 1;
   localparam int OW_BITS = (`SWU_OFM_W > 1) ? $clog2(`SWU_OFM_W) : 1;
   localparam int OH_BITS = (`SWU_OFM_H > 1) ? $clog2(`SWU_OFM_H) : 1;

   logic [CH_BITS-1:0] ch;
   logic [K_BITS-1:0]  kw;
   logic [K_BITS-1:0]  kh;
   logic [OW_BITS-1:0] ocol;
   logic [OH_BITS-1:0] orow;

   logic last_ch;
   logic last_kw;
   logic last_kh;
   logic last_col;
   logic last_row;

   swu_pkg::frame_idx_t needed_idx;

   //////////////////////////////////////////////////////////////////////
   // read address
   //////////////////////////////////////////////////////////////////////

   assign needed_idx = swu_pkg::frame_idx_t'(
      ((orow + kh) * `SWU_IFM_W + ocol + kw) * `SWU_CH_GRP + ch);

   // word index wrapped into the circular buffer
   assign rd_req_o.addr = swu_pkg::buf_addr_t'(needed_idx % `SWU_BUF_SIZE);

   // first word of the window, everything below may be overwritten
   assign release_idx_o = swu_pkg::frame_idx_t'((orow * `SWU_IFM_W + ocol) * `SWU_CH_GRP);

   // wait until the word is in the buffer and the output has space
   assign rd_fire_o = room_i && (needed_idx < wr_count_i);

   assign last_ch  = (ch == CH_BITS'(`SWU_CH_GRP - 1));
   assign last_kw  = (kw == K_BITS'(`SWU_K - 1));
   assign last_kh  = (kh == K_BITS'(`SWU_K - 1));
   assign last_col = (ocol == OW_BITS'(`SWU_OFM_W - 1));
   assign last_row = (orow == OH_BITS'(`SWU_OFM_H - 1));

   assign frame_done_o = rd_fire_o && last_ch && last_kw && last_kh && last_col && last_row;

   //////////////////////////////////////////////////////////////////////
   // trackers: channel, kernel column, kernel row, output column, row
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn || frame_done_o) begin
         ch   <= '0;
         kw   <= '0;
         kh   <= '0;
         ocol <= '0;
         orow <= '0;
      end else if (rd_fire_o) begin
         if (!last_ch) begin
            ch <= ch + 1'b1;
         end else begin
            ch <= '0;
            if (!last_kw) begin
               kw <= kw + 1'b1;
            end else begin
               kw <= '0;
               if (!last_kh) begin
                  kh <= kh + 1'b1;
               end else begin
                  kh <= '0;
                  // window complete, move the origin
                  if (!last_col) begin
                     ocol <= ocol + 1'b1;
                  end else begin
                     ocol <= '0;
                     orow <= orow + 1'b1;
                  end
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: swu_window_ram.sv
`default_nettype none

`include "swu_params.svh"

module swu_window_ram (
   input  wire                        clk,
   input  wire                        wr_en_i,
   input  wire swu_pkg::buf_addr_t    wr_addr_i,
   input  wire swu_pkg::pix_t         wr_data_i,
   input  wire                        rd_fire_i,
   input  wire swu_pkg::rd_req_t      rd_req_i,
   output logic                       rd_valid_o,
   output swu_pkg::pix_t              rd_data_o
);

   swu_pkg::pix_t mem [`SWU_BUF_SIZE];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // registered read port, data follows the request by one cycle
   always_ff @(posedge clk) begin
      rd_valid_o <= rd_fire_i;
      if (rd_fire_i) begin
         rd_data_o <= mem[rd_req_i.addr];
      end
   end

endmodule

`default_nettype wire

// File: swu_out_stage.sv
`default_nettype none

module swu_out_stage (
   input  wire                   clk,
   input  wire                   resetn,
   input  wire                   rd_fire_i,
   input  wire                   rd_valid_i,
   input  wire swu_pkg::pix_t    rd_data_i,
   input  wire                   out_ready_i,
   output logic                  out_valid_o,
   output swu_pkg::pix_t         out_data_o,
   output logic                  room_o
);

   swu_pkg::pix_t q_data [2];
   logic [1:0] q_cnt;
   logic [1:0] used;
   logic q_valid;
   logic out_fire;
   logic pop;
   logic push;
   logic push_slot;

   // oldest stored word first, else the word just read
   assign q_valid     = (q_cnt != 2'd0);
   assign out_valid_o = q_valid || rd_valid_i;
   assign out_data_o  = q_valid ? q_data[0] : rd_data_i;
   assign out_fire    = out_valid_o && out_ready_i;

   assign pop       = q_valid && out_ready_i;
   assign push      = rd_valid_i && !(!q_valid && out_ready_i);
   assign push_slot = pop ? (q_cnt == 2'd2) : (q_cnt == 2'd1);

   // stored words plus reads in flight
   assign room_o = (used < 2'd2);

   //////////////////////////////////////////////////////////////////////
   // occupancy
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn) begin
         used  <= '0;
         q_cnt <= '0;
      end else begin
         case ({rd_fire_i, out_fire})
            2'b10:   used <= used + 2'd1;
            2'b01:   used <= used - 2'd1;
            default: used <= used;
         endcase
         case ({push, pop})
            2'b10:   q_cnt <= q_cnt + 2'd1;
            2'b01:   q_cnt <= q_cnt - 2'd1;
            default: q_cnt <= q_cnt;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         q_data[0] <= q_data[1];
      end
      if (push) begin
         q_data[push_slot] <= rd_data_i;
      end
   end

endmodule

`default_nettype wire

// File: sliding_window_unit.sv
`default_nettype none

module sliding_window_unit (
   input  wire                   clk,
   input  wire                   resetn,
   input  wire swu_pkg::pix_t    in_data_i,
   input  wire                   in_valid_i,
   output logic                  in_ready_o,
   output swu_pkg::pix_t         out_data_o,
   output logic                  out_valid_o,
   input  wire                   out_ready_i
);

   logic                wr_en;
   swu_pkg::buf_addr_t  wr_addr;
   swu_pkg::frame_idx_t wr_count;
   swu_pkg::frame_idx_t release_idx;
   swu_pkg::rd_req_t    rd_req;
   logic                rd_fire;
   logic                rd_valid;
   swu_pkg::pix_t       rd_data;
   logic                room;
   logic                frame_done;

   //////////////////////////////////////////////////////////////////////
   // write process, pointer trackers, buffer, output stage
   //////////////////////////////////////////////////////////////////////

   swu_write_ctrl u_write_ctrl (
      .clk           (clk),
      .resetn        (resetn),
      .in_valid_i    (in_valid_i),
      .frame_done_i  (frame_done),
      .release_idx_i (release_idx),
      .in_ready_o    (in_ready_o),
      .wr_en_o       (wr_en),
      .wr_addr_o     (wr_addr),
      .wr_count_o    (wr_count)
   );

   swu_window_gen u_window_gen (
      .clk           (clk),
      .resetn        (resetn),
      .wr_count_i    (wr_count),
      .room_i        (room),
      .rd_req_o      (rd_req),
      .rd_fire_o     (rd_fire),
      .release_idx_o (release_idx),
      .frame_done_o  (frame_done)
   );

   swu_window_ram u_window_ram (
      .clk        (clk),
      .wr_en_i    (wr_en),
      .wr_addr_i  (wr_addr),
      .wr_data_i  (in_data_i),
      .rd_fire_i  (rd_fire),
      .rd_req_i   (rd_req),
      .rd_valid_o (rd_valid),
      .rd_data_o  (rd_data)
   );

   swu_out_stage u_out_stage (
      .clk         (clk),
      .resetn      (resetn),
      .rd_fire_i   (rd_fire),
      .rd_valid_i  (rd_valid),
      .rd_data_i   (rd_data),
      .out_ready_i (out_ready_i),
      .out_valid_o (out_valid_o),
      .out_data_o  (out_data_o),
      .room_o      (room)
   );

endmodule

`default_nettype wire

// File: tb_swu_asserts.sv
`default_nettype none

`include "swu_params.svh"

module tb_swu_asserts (
   input wire                        clk,
   input wire                        resetn,
   input wire                        out_valid_i,
   input wire                        out_ready_i,
   input wire swu_pkg::pix_t         out_data_i,
   input wire swu_pkg::frame_idx_t   wr_count_i,
   input wire swu_pkg::frame_idx_t   release_idx_i
);
   timeunit 1ns;
   timeprecision 1ps;

   int error_count = 0;
   swu_pkg::frame_idx_t unreleased;

   // words written but not yet released by the window
   assign unreleased = wr_count_i - release_idx_i;

   // held data under back-pressure
   a_out_stable: assert property (@(posedge clk) disable iff (!resetn)
      (out_valid_i && !out_ready_i) |=> $stable(out_data_i))
      else begin
         error_count = error_count + 1;
         $error("out_data_o changed while out_ready_i was low");
      end

   a_valid_known: assert property (@(posedge clk) resetn |-> !$isunknown(out_valid_i))
      else begin
         error_count = error_count + 1;
         $error("out_valid_o is unknown after reset");
      end

   // release never passes the write count, writes never pass the buffer size
   a_no_overrun: assert property (@(posedge clk) disable iff (!resetn)
      unreleased <= swu_pkg::frame_idx_t'(`SWU_BUF_SIZE))
      else begin
         error_count = error_count + 1;
         $error("more unreleased words than buffer entries");
      end

endmodule

bind sliding_window_unit tb_swu_asserts u_asserts (
   .clk           (clk),
   .resetn        (resetn),
   .out_valid_i   (out_valid_o),
   .out_ready_i   (out_ready_i),
   .out_data_i    (out_data_o),
   .wr_count_i    (wr_count),
   .release_idx_i (release_idx)
);

`default_nettype wire

// File: tb_sliding_window_unit.sv
`default_nettype none

`include "swu_params.svh"

module tb_sliding_window_unit;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int FRAME_WORDS    = `SWU_FRAME_WORDS;
   localparam int WIN_WORDS      = `SWU_WIN_WORDS;
   localparam int BUF_SIZE       = `SWU_BUF_SIZE;
   localparam int FRAMES         = 2;
   localparam int CLK_PERIOD     = 10;
   localparam int RESET_CYCLES   = 16;
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + 40 * FRAMES * WIN_WORDS;

   logic          clk = 1'b0;
   logic          resetn = 1'b0;
   swu_pkg::pix_t in_data_i = '0;
   logic          in_valid_i = 1'b0;
   logic          in_ready_o;
   swu_pkg::pix_t out_data_o;
   logic          out_valid_o;
   logic          out_ready_i = 1'b0;

   // input frame followed by the expected window words
   swu_pkg::pix_t stim [FRAME_WORDS + WIN_WORDS];
   logic [15:0]   lfsr = 16'd42;
   logic          running = 1'b0;
   int            in_pos = 0;
   int            out_pos = 0;
   int            buf_stalls = 0;

   sliding_window_unit u_dut (
      .clk         (clk),
      .resetn      (resetn),
      .in_data_i   (in_data_i),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .out_data_o  (out_data_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // fibonacci form, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] state);
      logic fb;
      fb = state[15] ^ state[13] ^ state[12] ^ state[10];
      return {state[14:0], fb};
   endfunction

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Simulation FAILED");
      $fatal(1, "run stopped at %0t", $time);
   endtask

   task automatic check_pix(input string name, input swu_pkg::pix_t got,
                            input swu_pkg::pix_t exp);
      if (got !== exp) begin
         abort_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         abort_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         abort_run($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // stream driver and output checker
   //////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      logic b0;
      logic b1;
      if (running) begin
         if (in_valid_i && in_ready_o) begin
            in_pos = in_pos + 1;
         end else if (in_valid_i && (in_pos % FRAME_WORDS) >= BUF_SIZE) begin
            // stalled by unreleased words, not by the end of a frame
            buf_stalls = buf_stalls + 1;
         end
         if (out_valid_o && out_ready_i) begin
            if (out_pos >= FRAMES * WIN_WORDS) begin
               abort_run("DUT produced more output words than the frames contain");
            end else begin
               check_pix("out_data_o", out_data_o, stim[FRAME_WORDS + out_pos % WIN_WORDS]);
               out_pos = out_pos + 1;
            end
         end
         if (in_valid_i && !in_ready_o) begin
            // hold the offered word
         end else if (in_pos < FRAMES * FRAME_WORDS) begin
            lfsr = lfsr_next(lfsr);
            b0 = lfsr[0];
            lfsr = lfsr_next(lfsr);
            b1 = lfsr[0];
            in_valid_i <= b0 | b1;
            in_data_i  <= stim[in_pos % FRAME_WORDS];
         end else begin
            in_valid_i <= 1'b0;
         end
         lfsr = lfsr_next(lfsr);
         out_ready_i <= lfsr[0];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      $readmemh("swu_stimulus.mem", stim);
      if ($isunknown(stim[FRAME_WORDS + WIN_WORDS - 1])) begin
         abort_run("stimulus file swu_stimulus.mem is missing or too short");
      end
      repeat (RESET_CYCLES) @(posedge clk);
      resetn <= 1'b1;
      // idle, nothing offered yet
      repeat (4) begin
         @(posedge clk);
         check_flag("out_valid_o", out_valid_o, 1'b0);
         check_flag("in_ready_o", in_ready_o, 1'b1);
      end
      running <= 1'b1;
      wait (out_pos == FRAMES * WIN_WORDS);
      // extra words would show up here
      repeat (20) @(posedge clk);
      check_count("accepted input words", in_pos, FRAMES * FRAME_WORDS);
      $display("input stalls on a full buffer: %0d", buf_stalls);
      if (buf_stalls == 0) begin
         abort_run("in_ready_o never dropped while the buffer was full");
      end
      if (u_dut.u_asserts.error_count != 0) begin
         abort_run("a bound assertion on the DUT failed");
      end else begin
         $display("Simulation PASSED");
         $finish;
      end
   end

   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      abort_run("watchdog expired before all output words arrived");
   end

endmodule

`default_nettype wire

// File: swu_stimulus.mem
// entries 0 to 17: input words, pixel index in the high nibble, channel group A or B low
// entries 18 to 49: expected words by output row, output col, kernel row, kernel col, channel
0A
0B
1A
1B
2A
2B
3A
3B
4A
4B
5A
5B
6A
6B
7A
7B
8A
8B
0A
0B
1A
1B
3A
3B
4A
4B
1A
1B
2A
2B
4A
4B
5A
5B
3A
3B
4A
4B
6A
6B
7A
7B
4A
4B
5A
5B
7A
7B
8A
8B

// File: sliding_window_unit.f
+incdir+.
swu_pkg.sv
swu_write_ctrl.sv
swu_window_gen.sv
swu_window_ram.sv
swu_out_stage.sv
sliding_window_unit.sv
tb_swu_asserts.sv
tb_sliding_window_unit.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := tb_sliding_window_unit
FILELIST  := sliding_window_unit.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
